// ==== src.f ====
+incdir+tb
hdl/exe_pkg.sv
hdl/alu_add.sv
hdl/alu_shift.sv
hdl/alu_logic.sv
hdl/alu.sv
hdl/exe_alu_stage.sv
tb/tb_exe_alu_stage.sv

// ==== Bender.yml ====
package:
  name: exe_alu_stage

sources:
  - hdl/exe_pkg.sv
  - hdl/alu_add.sv
  - hdl/alu_shift.sv
  - hdl/alu_logic.sv
  - hdl/alu.sv
  - hdl/exe_alu_stage.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_exe_alu_stage.sv

// ==== tb/tb_alu_ref.svh ====
// Reference model for ALU results and Fibonacci LFSR stimulus source
`ifndef TB_ALU_REF_SVH
`define TB_ALU_REF_SVH

function automatic bus64_t sext_word(logic [31:0] w);
    return {{32{w[31]}}, w};
endfunction

// Expected result straight from the ISA definitions
function automatic bus64_t ref_result(instr_type_t op, exe_unit_t unit_sel, bus64_t a, bus64_t b);
    bus64_t a_uw;
    bus64_t r;
    a_uw = {32'b0, a[31:0]};
    r    = '0;
    if (unit_sel == UNIT_SYSTEM) begin
        return a;
    end
    if (unit_sel != UNIT_ALU) begin
        return '0;
    end
    case (op)
        ADD:       r = a + b;
        SUB:       r = a - b;
        ADDW:      r = sext_word(a[31:0] + b[31:0]);
        SUBW:      r = sext_word(a[31:0] - b[31:0]);
        ADDUW:     r = a_uw + b;
        SH1ADD:    r = (a << 1) + b;
        SH2ADD:    r = (a << 2) + b;
        SH3ADD:    r = (a << 3) + b;
        SH1ADDUW:  r = (a_uw << 1) + b;
        SH2ADDUW:  r = (a_uw << 2) + b;
        SH3ADDUW:  r = (a_uw << 3) + b;
        SLL:       r = a << b[5:0];
        SRL:       r = a >> b[5:0];
        SRA:       r = $signed(a) >>> b[5:0];
        SLLW:      r = sext_word(a[31:0] << b[4:0]);
        SRLW:      r = sext_word(a[31:0] >> b[4:0]);
        SRAW:      r = sext_word($signed(a[31:0]) >>> b[4:0]);
        SLLIUW:    r = a_uw << b[5:0];
        SLT:       r = {63'b0, $signed(a) < $signed(b)};
        SLTU:      r = {63'b0, a < b};
        AND_INST:  r = a & b;
        OR_INST:   r = a | b;
        XOR_INST:  r = a ^ b;
        XNOR_INST: r = ~(a ^ b);
        ORN:       r = a | ~b;
        ANDN:      r = a & ~b;
        ZEXTW:     r = a_uw;
        default:   r = '0;
    endcase
    return r;
endfunction

// Taps 32, 22, 2, 1; one step per returned bit
function automatic bus64_t lfsr_bits(int unsigned n);
    bus64_t      bits;
    logic        fb;
    int unsigned i;
    bits = '0;
    for (i = 0; i < n; i++) begin
        fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        bits       = {bits[62:0], fb};
    end
    return bits;
endfunction

`endif

// ==== tb/tb_exe_alu_stage.sv ====
// Testbench for the ALU execution stage: clock, reset, stimulus, scoreboard and checks

`timescale 1ns/10ps

module tb_exe_alu_stage;
    import exe_pkg::*;

    localparam int     CLK_HALF     = 20;
    localparam int     WAIT_LIMIT   = 200;
    localparam int     RANDOM_COUNT = 400;
    localparam bus64_t PAIR_RS1 [3] = '{64'h0000_0001_7fff_ffff, 64'hffff_ffff_ffff_fff0,
                                        64'h8765_4321_8000_0000};
    localparam bus64_t PAIR_RS2 [3] = '{64'h0000_0000_0000_0001, 64'h0000_0000_0000_0003,
                                        64'hffff_ffff_ffff_ffe5};

    logic                 clk_i;
    logic                 rst_n_i;
    logic                 instr_valid_i;
    logic                 instr_ready_o;
    rr_exe_arith_instr_t  instr_i;
    logic                 wb_valid_o;
    logic                 wb_ready_i;
    exe_wb_scalar_instr_t wb_o;

    logic [31:0]          lfsr_state = 32'd89318;
    logic                 ready_random;
    int unsigned          seq = 0;
    exe_wb_scalar_instr_t exp_q [$];
    exe_wb_scalar_instr_t exp_head;
    int                   exp_count = 0;
    logic                 in_hs;
    logic                 in_kept;

    `include "tb_alu_ref.svh"

    exe_alu_stage dut_i (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_ready_o (instr_ready_o),
        .instr_i       (instr_i),
        .wb_valid_o    (wb_valid_o),
        .wb_ready_i    (wb_ready_i),
        .wb_o          (wb_o)
    );

    initial begin
        clk_i = 1'b0;
        forever begin
            #CLK_HALF clk_i = ~clk_i;
        end
    end

    task automatic abort_run();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic report_error(string msg);
        $display("ERROR at %0t: %s", $time, msg);
        abort_run();
    endtask

    task automatic report_mismatch(string field);
        $display("Mismatch at %0t: field %s differs from expected", $time, field);
        abort_run();
    endtask

    function automatic exe_wb_scalar_instr_t expected_output(rr_exe_arith_instr_t instr);
        exe_wb_scalar_instr_t e;
        e.valid      = 1'b1;
        e.pc         = instr.pc;
        e.instr_type = instr.instr_type;
        e.rd         = instr.rd;
        e.prd        = instr.prd;
        e.regfile_we = instr.regfile_we;
        e.csr_addr   = instr.imm[11:0];
        e.gl_index   = instr.gl_index;
        e.result     = ref_result(instr.instr_type, instr.unit, instr.data_rs1, instr.data_rs2);
        return e;
    endfunction

    // Drive one instruction and hold it until the handshake edge
    task automatic send(instr_type_t op, exe_unit_t unit_sel, bus64_t rs1, bus64_t rs2,
                        bus64_t imm);
        rr_exe_arith_instr_t pkt;
        int                  waited;
        pkt.pc         = 64'h8000_0000 + 64'(seq) * 4;
        pkt.instr_type = op;
        pkt.unit       = unit_sel;
        pkt.rd         = reg_t'(seq);
        pkt.prd        = phys_reg_t'(seq * 5);
        pkt.regfile_we = seq[0];
        pkt.imm        = imm;
        pkt.gl_index   = gl_index_t'(seq);
        pkt.data_rs1   = rs1;
        pkt.data_rs2   = rs2;
        seq++;
        waited = 0;
        @(posedge clk_i);
        instr_valid_i <= 1'b1;
        instr_i       <= pkt;
        @(negedge clk_i);
        while (!instr_ready_o) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                report_error("instruction was never accepted by the stage");
            end
            @(negedge clk_i);
        end
    endtask

    // Half the cycles stall in the random phase
    always @(posedge clk_i) begin
        if (ready_random) begin
            wb_ready_i <= lfsr_bits(1) != 0;
        end else begin
            wb_ready_i <= rst_n_i;
        end
    end

    // ------------------------------------------------------------------------
    // Scoreboard
    // ------------------------------------------------------------------------

    assign in_hs   = instr_valid_i && instr_ready_o;
    assign in_kept = in_hs && (instr_i.unit == UNIT_ALU || instr_i.unit == UNIT_SYSTEM);

    always @(posedge clk_i) begin
        if (rst_n_i) begin
            if (wb_valid_o && wb_ready_i && exp_q.size() > 0) begin
                void'(exp_q.pop_front());
            end
            if (in_kept) begin
                exp_q.push_back(expected_output(instr_i));
            end
        end
        exp_count <= exp_q.size();
        if (exp_q.size() > 0) begin
            exp_head <= exp_q[0];
        end else begin
            exp_head <= '0;
        end
    end

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------

    assert property (@(posedge clk_i) (!rst_n_i || $rose(rst_n_i)) |-> !wb_valid_o)
        else report_error("wb_valid_o high during or right after reset");

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_valid_o && wb_ready_i |-> exp_count > 0)
        else report_error("a result left the stage with no instruction pending");

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_valid_o && wb_ready_i |-> wb_o.valid == exp_head.valid)
        else report_mismatch("valid");
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_valid_o && wb_ready_i |-> wb_o.result == exp_head.result)
        else report_mismatch("result");
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_valid_o && wb_ready_i |-> wb_o.pc == exp_head.pc)
        else report_mismatch("pc");
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_valid_o && wb_ready_i |-> wb_o.instr_type == exp_head.instr_type)
        else report_mismatch("instr_type");
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_valid_o && wb_ready_i |-> wb_o.rd == exp_head.rd && wb_o.prd == exp_head.prd)
        else report_mismatch("rd/prd");
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_valid_o && wb_ready_i |-> wb_o.regfile_we == exp_head.regfile_we)
        else report_mismatch("regfile_we");
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_valid_o && wb_ready_i |-> wb_o.csr_addr == exp_head.csr_addr)
        else report_mismatch("csr_addr");
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_valid_o && wb_ready_i |-> wb_o.gl_index == exp_head.gl_index)
        else report_mismatch("gl_index");

    // Back-pressure holds the entry
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_valid_o && !wb_ready_i |-> !instr_ready_o ##1 wb_valid_o && $stable(wb_o))
        else report_error("held result changed or input accepted while stalled");

    // Empty register or draining output takes a new instruction
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !wb_valid_o || wb_ready_i |-> instr_ready_o)
        else report_error("stage refused an instruction while it had room");

    // One cycle latency and no output for dropped units
    assert property (@(posedge clk_i) disable iff (!rst_n_i) in_kept |=> wb_valid_o)
        else report_error("accepted instruction did not appear one cycle later");
    assert property (@(posedge clk_i) disable iff (!rst_n_i) in_hs && !in_kept |=> !wb_valid_o)
        else report_error("branch or memory instruction reached the output");

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------

    initial begin : main_seq
        int          idx;
        int          waited;
        int          unit_pick;
        int          op_pick;
        instr_type_t op;
        exe_unit_t   unit_sel;
        rst_n_i       = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        wb_ready_i    = 1'b0;
        ready_random  = 1'b0;
        repeat (16) @(posedge clk_i);
        rst_n_i <= 1'b1;
        @(negedge clk_i);

        // Every ALU opcode against three operand pairs
        for (idx = 0; idx < 3 * 27; idx++) begin
            send(instr_type_t'(idx % 27), UNIT_ALU, PAIR_RS1[idx / 27], PAIR_RS2[idx / 27],
                 64'h0);
        end

        // Unit filtering keeps order of the survivors
        send(CSRRW, UNIT_SYSTEM, 64'hdead_beef_0123_4567, 64'h5, 64'h0000_0000_0000_0341);
        send(ADD, UNIT_BRANCH, 64'h10, 64'h20, 64'h0);
        send(ADD, UNIT_MEM, 64'h30, 64'h40, 64'h0);
        send(CSRRW, UNIT_SYSTEM, 64'h0000_0000_cafe_f00d, 64'h0, 64'hffff_ffff_ffff_fabc);
        send(SUB, UNIT_ALU, 64'h5, 64'h7, 64'h0);

        ready_random = 1'b1;
        for (idx = 0; idx < RANDOM_COUNT; idx++) begin
            unit_pick = int'(lfsr_bits(3));
            op_pick   = int'(lfsr_bits(5) % 64'd27);
            op        = instr_type_t'(op_pick);
            case (unit_pick)
                5:       unit_sel = UNIT_SYSTEM;
                6:       unit_sel = UNIT_BRANCH;
                7:       unit_sel = UNIT_MEM;
                default: unit_sel = UNIT_ALU;
            endcase
            if (unit_sel == UNIT_SYSTEM) begin
                op = CSRRW;
            end
            send(op, unit_sel, lfsr_bits(64), lfsr_bits(64), lfsr_bits(12));
        end

        @(posedge clk_i);
        instr_valid_i <= 1'b0;
        @(negedge clk_i);
        ready_random = 1'b0;
        waited = 0;
        while (exp_count != 0 || wb_valid_o) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                report_error("pending results never drained from the stage");
            end
            @(negedge clk_i);
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== hdl/exe_alu_stage.sv ====
// ALU execution stage top: elastic one-entry output register around the ALU

`timescale 1ns/10ps

module exe_alu_stage (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic                          instr_valid_i,
    output logic                          instr_ready_o,
    input  exe_pkg::rr_exe_arith_instr_t  instr_i,
    output logic                          wb_valid_o,
    input  logic                          wb_ready_i,
    output exe_pkg::exe_wb_scalar_instr_t wb_o
);
    import exe_pkg::*;

    exe_wb_scalar_instr_t alu_out;
    exe_wb_scalar_instr_t wb_data_q;
    logic                 wb_valid_q;
    logic                 instr_hs;

    alu alu_inst (
        .instruction_i (instr_i),
        .instruction_o (alu_out)
    );

    // ------------------------------------------------------------------------
    // Output register
    // ------------------------------------------------------------------------

    // Free slot, or the held result leaves this cycle
    assign instr_ready_o = ~wb_valid_q | wb_ready_i;
    assign instr_hs      = instr_valid_i & instr_ready_o;

    // Dropped units load an empty entry
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_valid_q <= 1'b0;
        end else if (instr_hs) begin
            wb_valid_q <= alu_out.valid;
        end else if (wb_ready_i) begin
            wb_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (instr_hs) begin
            wb_data_q <= alu_out;
        end
    end

    assign wb_valid_o = wb_valid_q;

    always_comb begin
        wb_o       = wb_data_q;
        wb_o.valid = wb_valid_q;
    end

    // ------------------------------------------------------------------------
    // Assertions
    // ------------------------------------------------------------------------

    // Held result must not change under back-pressure
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_valid_o && !wb_ready_i |=> $stable(wb_o))
        else $error("exe_alu_stage: wb_o changed while stalled");

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !$isunknown(wb_valid_o))
        else $error("exe_alu_stage: wb_valid_o unknown");

endmodule

// ==== hdl/alu.sv ====
// Combinational ALU: operand preparation, sub-unit results, result selection, write-back metadata

`timescale 1ns/10ps

module alu (
    input  exe_pkg::rr_exe_arith_instr_t  instruction_i,
    output exe_pkg::exe_wb_scalar_instr_t instruction_o
);
    import exe_pkg::*;

    bus64_t      data_rs1;
    bus64_t      data_rs2;
    instr_type_t op;
    bus64_t      data_rs1_extended;
    bus64_t      data_rs1_shifted;
    bus64_t      add_result;
    bus64_t      shift_result;
    bus64_t      logic_result;
    bus64_t      result_modules;
    logic        op_known;

    assign data_rs1 = instruction_i.data_rs1;
    assign data_rs2 = instruction_i.data_rs2;
    assign op       = instruction_i.instr_type;

    // ------------------------------------------------------------------------
    // Operand preparation
    // ------------------------------------------------------------------------

    // Word and .UW forms work on rs1[31:0]
    always_comb begin
        case (op)
            ADDUW, SH1ADDUW, SH2ADDUW, SH3ADDUW, ZEXTW, SLLIUW, SLLW, SRLW: begin
                data_rs1_extended = {32'b0, data_rs1[31:0]};
            end
            SRAW: begin
                data_rs1_extended = {{32{data_rs1[31]}}, data_rs1[31:0]};
            end
            default: begin
                data_rs1_extended = data_rs1;
            end
        endcase
    end

    // Zba pre-shift ahead of the adder
    always_comb begin
        case (op)
            SH1ADD, SH1ADDUW: data_rs1_shifted = {data_rs1_extended[62:0], 1'b0};
            SH2ADD, SH2ADDUW: data_rs1_shifted = {data_rs1_extended[61:0], 2'b0};
            SH3ADD, SH3ADDUW: data_rs1_shifted = {data_rs1_extended[60:0], 3'b0};
            default:          data_rs1_shifted = data_rs1_extended;
        endcase
    end

    // ------------------------------------------------------------------------
    // Sub-units
    // ------------------------------------------------------------------------

    alu_add alu_add_inst (
        .data_rs1_i   (data_rs1_shifted),
        .data_rs2_i   (data_rs2),
        .instr_type_i (op),
        .result_o     (add_result)
    );

    alu_shift alu_shift_inst (
        .data_rs1_i   (data_rs1_extended),
        .data_rs2_i   (data_rs2),
        .instr_type_i (op),
        .result_o     (shift_result)
    );

    alu_logic alu_logic_inst (
        .data_rs1_i   (data_rs1),
        .data_rs2_i   (data_rs2),
        .instr_type_i (op),
        .result_o     (logic_result)
    );

    // Pick the unit by opcode group
    always_comb begin
        op_known = 1'b1;
        case (op)
            ADD, SUB, ADDW, SUBW, ADDUW, SH1ADD, SH2ADD, SH3ADD,
            SH1ADDUW, SH2ADDUW, SH3ADDUW, SLT, SLTU: begin
                result_modules = add_result;
            end
            SLL, SRL, SRA, SLLW, SRLW, SRAW, SLLIUW: begin
                result_modules = shift_result;
            end
            AND_INST, OR_INST, XOR_INST, XNOR_INST, ORN, ANDN: begin
                result_modules = logic_result;
            end
            ZEXTW, CSRRW: begin
                result_modules = '0;
            end
            default: begin
                result_modules = '0;
                op_known       = 1'b0;
            end
        endcase
    end

    // ------------------------------------------------------------------------
    // Result
    // ------------------------------------------------------------------------

    always_comb begin
        if (instruction_i.unit == UNIT_SYSTEM) begin
            // CSR write data
            instruction_o.result = data_rs1;
        end else if (instruction_i.unit != UNIT_ALU) begin
            instruction_o.result = '0;
        end else begin
            case (op)
                ADDW, SUBW, SLLW, SRLW, SRAW: begin
                    instruction_o.result = {{32{result_modules[31]}}, result_modules[31:0]};
                end
                ZEXTW: begin
                    instruction_o.result = data_rs1_extended;
                end
                default: begin
                    instruction_o.result = result_modules;
                end
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // Write-back metadata
    // ------------------------------------------------------------------------

    // Branch and memory ops are dropped here
    assign instruction_o.valid      = (instruction_i.unit == UNIT_ALU) |
                                      (instruction_i.unit == UNIT_SYSTEM);
    assign instruction_o.pc         = instruction_i.pc;
    assign instruction_o.instr_type = instruction_i.instr_type;
    assign instruction_o.rd         = instruction_i.rd;
    assign instruction_o.prd        = instruction_i.prd;
    assign instruction_o.regfile_we = instruction_i.regfile_we;
    assign instruction_o.csr_addr   = instruction_i.imm[CSR_ADDR_SIZE-1:0];
    assign instruction_o.gl_index   = instruction_i.gl_index;

    // Decode must never pass an undefined opcode on to write-back
    always_comb begin
        assert final (!instruction_o.valid || op_known)
            else $error("alu: valid result with undefined opcode %0d", op);
    end

endmodule

// ==== hdl/alu_logic.sv ====
// Bitwise logic unit including inverted-operand forms

`timescale 1ns/10ps

module alu_logic (
    input  exe_pkg::bus64_t      data_rs1_i,
    input  exe_pkg::bus64_t      data_rs2_i,
    input  exe_pkg::instr_type_t instr_type_i,
    output exe_pkg::bus64_t      result_o
);
    import exe_pkg::*;

    always_comb begin
        case (instr_type_i)
            AND_INST:  result_o = data_rs1_i & data_rs2_i;
            OR_INST:   result_o = data_rs1_i | data_rs2_i;
            XOR_INST:  result_o = data_rs1_i ^ data_rs2_i;
            // Zbb forms
            XNOR_INST: result_o = ~(data_rs1_i ^ data_rs2_i);
            ORN:       result_o = data_rs1_i | ~data_rs2_i;
            ANDN:      result_o = data_rs1_i & ~data_rs2_i;
            default:   result_o = '0;
        endcase
    end

endmodule

// ==== hdl/alu_shift.sv ====
// Barrel shifter for 64-bit and word-wide logical and arithmetic shifts

`timescale 1ns/10ps

module alu_shift (
    input  exe_pkg::bus64_t      data_rs1_i,
    input  exe_pkg::bus64_t      data_rs2_i,
    input  exe_pkg::instr_type_t instr_type_i,
    output exe_pkg::bus64_t      result_o
);
    import exe_pkg::*;

    logic [5:0] shamt;

    // Word shifts only look at five bits of rs2
    always_comb begin
        case (instr_type_i)
            SLLW, SRLW, SRAW: begin
                shamt = {1'b0, data_rs2_i[4:0]};
            end
            default: begin
                shamt = data_rs2_i[5:0];
            end
        endcase
    end

    // rs1 arrives already zero or sign extended for the word forms,
    // so only the low 32 bits matter there
    always_comb begin
        case (instr_type_i)
            SLL, SLLW, SLLIUW: begin
                result_o = data_rs1_i << shamt;
            end
            SRL, SRLW: begin
                result_o = data_rs1_i >> shamt;
            end
            SRA, SRAW: begin
                result_o = $signed(data_rs1_i) >>> shamt;
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

// ==== hdl/alu_add.sv ====
// Adder/subtractor with signed and unsigned set-less-than results

`timescale 1ns/10ps

module alu_add (
    input  exe_pkg::bus64_t      data_rs1_i,
    input  exe_pkg::bus64_t      data_rs2_i,
    input  exe_pkg::instr_type_t instr_type_i,
    output exe_pkg::bus64_t      result_o
);
    import exe_pkg::*;

    logic        subtract;
    bus64_t      operand_b;
    logic [64:0] sum;
    logic        lt_signed;
    logic        lt_unsigned;

    // Compares reuse the subtraction
    always_comb begin
        case (instr_type_i)
            SUB, SUBW, SLT, SLTU: subtract = 1'b1;
            default:              subtract = 1'b0;
        endcase
    end

    // Two's complement by inverting b and feeding the carry in
    assign operand_b = subtract ? ~data_rs2_i : data_rs2_i;
    assign sum       = {1'b0, data_rs1_i} + {1'b0, operand_b} + {64'b0, subtract};

    // No carry out of a - b means a borrow, so a < b unsigned
    assign lt_unsigned = ~sum[64];

    // Opposite signs decide directly and otherwise the difference sign does
    assign lt_signed = (data_rs1_i[63] ^ data_rs2_i[63]) ? data_rs1_i[63] : sum[63];

    always_comb begin
        case (instr_type_i)
            SLT: begin
                result_o = {63'b0, lt_signed};
            end
            SLTU: begin
                result_o = {63'b0, lt_unsigned};
            end
            default: begin
                result_o = sum[63:0];
            end
        endcase
    end

endmodule

// ==== hdl/exe_pkg.sv ====
// Shared types for the integer ALU execution stage: data words, register tags, opcodes, units

package exe_pkg;

    // ------------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------------

    localparam int unsigned XLEN          = 64;
    localparam int unsigned PHYS_REG_BITS = 7;
    localparam int unsigned REG_BITS      = 5;
    localparam int unsigned GL_INDEX_BITS = 6;
    localparam int unsigned CSR_ADDR_SIZE = 12;

    // ------------------------------------------------------------------------
    // Basic types
    // ------------------------------------------------------------------------

    // Operand, immediate and result word
    typedef logic [XLEN-1:0]          bus64_t;

    // Renamed destination tag
    typedef logic [PHYS_REG_BITS-1:0] phys_reg_t;

    // Architectural register index
    typedef logic [REG_BITS-1:0]      reg_t;

    // Slot in the graduation list
    typedef logic [GL_INDEX_BITS-1:0] gl_index_t;

    typedef logic [CSR_ADDR_SIZE-1:0] csr_addr_t;

    // Operations handled by this stage
    typedef enum logic [4:0] {
        ADD,
        SUB,
        ADDW,
        SUBW,
        ADDUW,
        SH1ADD,
        SH2ADD,
        SH3ADD,
        SH1ADDUW,
        SH2ADDUW,
        SH3ADDUW,
        SLL,
        SRL,
        SRA,
        SLLW,
        SRLW,
        SRAW,
        SLLIUW,
        SLT,
        SLTU,
        AND_INST,
        OR_INST,
        XOR_INST,
        XNOR_INST,
        ORN,
        ANDN,
        ZEXTW,
        CSRRW
    } instr_type_t;

    // Functional unit the instruction was decoded for
    typedef enum logic [1:0] {
        UNIT_ALU,
        UNIT_SYSTEM,
        UNIT_BRANCH,
        UNIT_MEM
    } exe_unit_t;

    // ------------------------------------------------------------------------
    // Stage interfaces
    // ------------------------------------------------------------------------

    // Register-read to execute
    typedef struct packed {
        bus64_t      pc;
        instr_type_t instr_type;
        exe_unit_t   unit;
        reg_t        rd;
        phys_reg_t   prd;
        logic        regfile_we;
        bus64_t      imm;
        gl_index_t   gl_index;
        bus64_t      data_rs1;
        bus64_t      data_rs2;
    } rr_exe_arith_instr_t;

    // Execute to write-back
    typedef struct packed {
        logic        valid;
        bus64_t      pc;
        instr_type_t instr_type;
        reg_t        rd;
        phys_reg_t   prd;
        logic        regfile_we;
        csr_addr_t   csr_addr;
        gl_index_t   gl_index;
        bus64_t      result;
    } exe_wb_scalar_instr_t;

endpackage
